// ==== src/prbs_config.svh ====
// ------------------------------------------------------------
// build-time settings of the PRBS link tester
// word width, generator seed, lock threshold and the widths
// of the saturating error counters
// ------------------------------------------------------------
`ifndef PRBS_CONFIG_SVH
`define PRBS_CONFIG_SVH

// parallel word width, 32 or 64
// one word has to hold at least 31 bits of history so that it
// fully predicts the following word for every pattern
`define PRBS_DATA_WIDTH 32

// generator start word, truncated to the word width at load
// the upper 31 bits of the truncated value must not all be zero
`define PRBS_SEED 64'hA5C3_96E1_7B2D_4F81

// consecutive matching valid words the checker needs for lock
`define PRBS_LOCK_COUNT 16

// saturating counter widths for bit and word error totals
`define PRBS_BIT_COUNT_WIDTH 32
`define PRBS_WORD_COUNT_WIDTH 16

`endif

// ==== src/prbsPkg.sv ====
// ------------------------------------------------------------
// shared types of the PRBS link tester
// pattern select enum, checker lane status word and the
// error totals returned on a host read
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

package prbsPkg;

  // run-time pattern choice, held stable after reset
  typedef enum logic [1:0] {
    PRBS7  = 2'd0,
    PRBS15 = 2'd1,
    PRBS23 = 2'd2,
    PRBS31 = 2'd3
  } prbsPattern_e;

  // per-word report from the checker to the error counter
  // errorBits has a one for every received bit that differs
  // from the predicted bit
  typedef struct packed {
    logic                        valid;
    logic                        locked;
    logic [`PRBS_DATA_WIDTH-1:0] errorBits;
  } laneStatus_t;

  // totals handed to the host, both fields stick at all ones
  // rather than wrapping
  typedef struct packed {
    logic [`PRBS_BIT_COUNT_WIDTH-1:0]  bitErrors;
    logic [`PRBS_WORD_COUNT_WIDTH-1:0] wordErrors;
  } errorTotals_t;

endpackage

`default_nettype wire

// ==== src/prbsPoly.sv ====
// ------------------------------------------------------------
// parallel PRBS step
// computes the next data word of the selected pattern from
// the current word, for PRBS7, PRBS15, PRBS23 and PRBS31
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

module prbsPoly (
  input  wire prbsPkg::prbsPattern_e        patternSel,
  input  wire [`PRBS_DATA_WIDTH-1:0]       current,
  output logic [`PRBS_DATA_WIDTH-1:0]      next
);

  localparam int W = `PRBS_DATA_WIDTH;

  // ------------------------------------------------------------
  // serial recurrence unrolled over one word
  // ------------------------------------------------------------

  // the stream runs lsb first, so the low half of ext is the
  // current word and the high half fills in with the next word
  // each new bit looks back tapA and tapB places in the stream,
  // which may reach into bits formed earlier in this same loop
  function automatic logic [W-1:0] stepWord(
    input logic [W-1:0] cur,
    input int           tapA,
    input int           tapB
  );
    logic [2*W-1:0] ext;
    ext = '0;
    ext[W-1:0] = cur;
    for (int i = 0; i < W; i++) begin
      ext[W+i] = ext[W+i-tapA] ^ ext[W+i-tapB];
    end
    return ext[2*W-1:W];
  endfunction

  // all four patterns are formed in parallel and one is picked
  logic [W-1:0] next7;
  logic [W-1:0] next15;
  logic [W-1:0] next23;
  logic [W-1:0] next31;

  always_comb begin
    next7  = stepWord(current, 7, 6);
    next15 = stepWord(current, 15, 14);
    next23 = stepWord(current, 23, 18);
    next31 = stepWord(current, 31, 28);
  end

  // ------------------------------------------------------------
  // pattern select
  // ------------------------------------------------------------

  always_comb begin
    case (patternSel)
      prbsPkg::PRBS7:  next = next7;
      prbsPkg::PRBS15: next = next15;
      prbsPkg::PRBS23: next = next23;
      prbsPkg::PRBS31: next = next31;
      default:         next = next7;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/prbsGenerator.sv ====
// ------------------------------------------------------------
// PRBS pattern source
// steps the sequence word once per enabled cycle and drives
// it out as txData, with optional single-bit error insertion
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

module prbsGenerator (
  input  wire                           clk,
  input  wire                           nreset,
  input  wire prbsPkg::prbsPattern_e    patternSel,
  input  wire                           genEnable,
  input  wire                           insertError,
  output logic [`PRBS_DATA_WIDTH-1:0]   txData,
  output logic                          txValid
);

  localparam int W = `PRBS_DATA_WIDTH;

  // sequence state, never touched by error insertion
  logic [W-1:0] seqWord;
  logic [W-1:0] seqNext;
  // bit 0 flip applied only to the outgoing copy
  logic [W-1:0] errMask;

  prbsPoly poly_i (
    .patternSel (patternSel),
    .current    (seqWord),
    .next       (seqNext)
  );

  assign errMask = {{(W-1){1'b0}}, insertError};

  // ------------------------------------------------------------
  // sequence state and valid
  // ------------------------------------------------------------

  // the first word out after reset is the seed itself
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      seqWord <= W'(`PRBS_SEED);
      txValid <= 1'b0;
    end else begin
      txValid <= genEnable;
      if (genEnable) begin
        seqWord <= seqNext;
      end
    end
  end

  // output word, only meaningful while txValid is high
  always_ff @(posedge clk) begin
    if (genEnable) begin
      txData <= seqWord ^ errMask;
    end
  end

endmodule

`default_nettype wire

// ==== src/prbsChecker.sv ====
// ------------------------------------------------------------
// PRBS checker
// seeds itself from any received word, counts consecutive
// matches until lock, then compares each valid word against
// a free-running prediction and reports mismatching bits
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

module prbsChecker (
  input  wire                           clk,
  input  wire                           nreset,
  input  wire prbsPkg::prbsPattern_e    patternSel,
  input  wire [`PRBS_DATA_WIDTH-1:0]    rxData,
  input  wire                           rxValid,
  output prbsPkg::laneStatus_t          status,
  output logic                          locked,
  output logic                          errorFlag
);

  localparam int W          = `PRBS_DATA_WIDTH;
  localparam int LockCount  = `PRBS_LOCK_COUNT;
  localparam int CountWidth = $clog2(LockCount + 1);

  typedef enum logic [1:0] {
    stateSeed  = 2'd0,
    stateLock  = 2'd1,
    stateCheck = 2'd2
  } checkState_e;

  checkState_e           state;
  logic [CountWidth-1:0] matchCount;
  // expected value of the next valid word
  logic [W-1:0]          predWord;
  logic [W-1:0]          predSource;
  logic [W-1:0]          predNext;
  logic [W-1:0]          diffBits;
  logic                  wordMatch;

  // ------------------------------------------------------------
  // prediction
  // ------------------------------------------------------------

  // before lock the received word itself seeds the next
  // prediction, so the checker follows whatever arrives
  // once locked the prediction runs on its own, so a corrupted
  // word shows up as one error and does not spread
  assign predSource = (state == stateCheck) ? predWord : rxData;

  prbsPoly poly_i (
    .patternSel (patternSel),
    .current    (predSource),
    .next       (predNext)
  );

  assign diffBits  = rxData ^ predWord;
  assign wordMatch = (diffBits == '0);

  always_ff @(posedge clk) begin
    if (rxValid) begin
      predWord <= predNext;
    end
  end

  // ------------------------------------------------------------
  // lock state machine
  // ------------------------------------------------------------

  // lock is sticky, only reset brings the FSM back to seed
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state      <= stateSeed;
      matchCount <= '0;
    end else if (rxValid) begin
      case (state)
        stateSeed: begin
          state      <= stateLock;
          matchCount <= '0;
        end
        stateLock: begin
          if (!wordMatch) begin
            matchCount <= '0;
          end else if (matchCount == CountWidth'(LockCount - 1)) begin
            matchCount <= matchCount + 1'b1;
            state      <= stateCheck;
          end else begin
            matchCount <= matchCount + 1'b1;
          end
        end
        stateCheck: begin
          state <= stateCheck;
        end
        default: begin
          state <= stateSeed;
        end
      endcase
    end
  end

  assign locked = (state == stateCheck);

  // ------------------------------------------------------------
  // per-word report
  // ------------------------------------------------------------

  // the seed word has no prediction to compare against, so it
  // reports a clean mask
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      status    <= '0;
      errorFlag <= 1'b0;
    end else begin
      status.valid     <= rxValid;
      status.locked    <= locked;
      status.errorBits <= (rxValid && state != stateSeed) ? diffBits : '0;
      errorFlag        <= rxValid && locked && !wordMatch;
    end
  end

endmodule

`default_nettype wire

// ==== src/errorCounter.sv ====
// ------------------------------------------------------------
// error totals
// saturating bit and word error counts over locked words and
// a four-phase req/ack port that reads and clears them
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

module errorCounter (
  input  wire                         clk,
  input  wire                         nreset,
  input  wire prbsPkg::laneStatus_t   status,
  input  wire                         readReq,
  output logic                        readAck,
  output prbsPkg::errorTotals_t       readTotals
);

  localparam int W         = `PRBS_DATA_WIDTH;
  localparam int BitWidth  = `PRBS_BIT_COUNT_WIDTH;
  localparam int WordWidth = `PRBS_WORD_COUNT_WIDTH;
  localparam int PopWidth  = $clog2(W + 1);

  logic [BitWidth-1:0]  bitCount;
  logic [WordWidth-1:0] wordCount;
  logic [PopWidth-1:0]  bitInc;
  logic                 wordInc;
  // one extra bit catches the carry for saturation
  logic [BitWidth:0]    bitSum;
  logic [WordWidth:0]   wordSum;
  logic                 reqSync;
  logic                 capture;

  // number of ones in a mismatch mask
  function automatic logic [PopWidth-1:0] popCount(input logic [W-1:0] bits);
    logic [PopWidth-1:0] total;
    total = '0;
    for (int i = 0; i < W; i++) begin
      total = total + PopWidth'(bits[i]);
    end
    return total;
  endfunction

  // ------------------------------------------------------------
  // increments from the checker report
  // ------------------------------------------------------------

  // only words checked after lock contribute to the totals
  always_comb begin
    if (status.valid && status.locked) begin
      bitInc  = popCount(status.errorBits);
      wordInc = |status.errorBits;
    end else begin
      bitInc  = '0;
      wordInc = 1'b0;
    end
    bitSum  = {1'b0, bitCount} + (BitWidth + 1)'(bitInc);
    wordSum = {1'b0, wordCount} + (WordWidth + 1)'(wordInc);
  end

  // ------------------------------------------------------------
  // host handshake
  // ------------------------------------------------------------

  // readReq is resynchronized once, ack follows the synced level
  // capture happens on the single cycle where the synced request
  // is up and the ack has not yet followed
  assign capture = reqSync && !readAck;

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      reqSync <= 1'b0;
      readAck <= 1'b0;
    end else begin
      reqSync <= readReq;
      readAck <= reqSync;
    end
  end

  // errors landing in the capture cycle start the new counts
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      bitCount  <= '0;
      wordCount <= '0;
    end else if (capture) begin
      bitCount  <= BitWidth'(bitInc);
      wordCount <= WordWidth'(wordInc);
    end else begin
      bitCount  <= bitSum[BitWidth] ? '1 : bitSum[BitWidth-1:0];
      wordCount <= wordSum[WordWidth] ? '1 : wordSum[WordWidth-1:0];
    end
  end

  // held value the host samples while readAck is high
  always_ff @(posedge clk) begin
    if (capture) begin
      readTotals.bitErrors  <= bitCount;
      readTotals.wordErrors <= wordCount;
    end
  end

endmodule

`default_nettype wire

// ==== src/prbsTester.sv ====
// ------------------------------------------------------------
// PRBS link tester top level
// pattern generator on the transmit side, self-seeding checker
// on the receive side and the host-readable error totals
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

module prbsTester (
  input  wire                           clk,
  input  wire                           nreset,
  input  wire prbsPkg::prbsPattern_e    patternSel,
  input  wire                           genEnable,
  input  wire                           insertError,
  input  wire [`PRBS_DATA_WIDTH-1:0]    rxData,
  input  wire                           rxValid,
  input  wire                           readReq,
  output logic [`PRBS_DATA_WIDTH-1:0]   txData,
  output logic                          txValid,
  output logic                          locked,
  output logic                          errorFlag,
  output logic                          readAck,
  output prbsPkg::errorTotals_t         readTotals
);

  // checker report feeding the counter
  prbsPkg::laneStatus_t status;

  prbsGenerator prbsGenerator_i (
    .clk         (clk),
    .nreset      (nreset),
    .patternSel  (patternSel),
    .genEnable   (genEnable),
    .insertError (insertError),
    .txData      (txData),
    .txValid     (txValid)
  );

  // both sides run the same pattern from the one select input
  prbsChecker prbsChecker_i (
    .clk        (clk),
    .nreset     (nreset),
    .patternSel (patternSel),
    .rxData     (rxData),
    .rxValid    (rxValid),
    .status     (status),
    .locked     (locked),
    .errorFlag  (errorFlag)
  );

  errorCounter errorCounter_i (
    .clk        (clk),
    .nreset     (nreset),
    .status     (status),
    .readReq    (readReq),
    .readAck    (readAck),
    .readTotals (readTotals)
  );

endmodule

`default_nettype wire

// ==== verif/prbsTesterTb.sv ====
// ------------------------------------------------------------
// testbench for the PRBS link tester
// clock and reset, looped-back lane with random gaps and bit
// flips, a serial model of the four patterns, and checks of
// tx words, lock, error flags and four-phase host reads
// ------------------------------------------------------------
`default_nettype none

`include "prbs_config.svh"

module prbsTesterTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int W         = `PRBS_DATA_WIDTH;
  localparam int LockWords = `PRBS_LOCK_COUNT + 1;
  // four patterns of about 400 cycles each plus margin
  localparam int MaxCycles = 4000;

  logic                  clk;
  logic                  nreset;
  prbsPkg::prbsPattern_e patternSel;
  logic                  genEnable;
  logic                  insertError;
  logic [W-1:0]          rxData;
  logic                  rxValid;
  logic                  readReq;
  logic [W-1:0]          txData;
  logic                  txValid;
  logic                  locked;
  logic                  errorFlag;
  logic                  readAck;
  prbsPkg::errorTotals_t readTotals;

  int          errorCount;
  int          checkCount;
  int          cycleCount;
  integer      seed;
  // generator model where pendWord is what txData should show next
  logic [W-1:0] modelWord;
  logic [W-1:0] pendWord;
  logic         pendValid;
  logic         pendIns;
  // word now on rxData and its difference from the true sequence
  logic         drivenValid;
  logic [W-1:0] drivenMask;
  int           rxWordCount;
  logic         modelLocked;
  logic [63:0]  bitTally;
  logic [63:0]  wordTally;
  // stimulus knobs where a flipRate of 0 keeps the lane clean
  int unsigned  flipRate;
  logic         wantInsert;

  prbsTester prbsTester_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // reference model and check helpers
  // ------------------------------------------------------------

  // serial LFSR in which hist[d-1] holds the sequence bit d places back
  function automatic logic [W-1:0] advanceWord(input logic [W-1:0] cur,
                                               input prbsPkg::prbsPattern_e sel);
    int           tapA;
    int           tapB;
    logic [W-1:0] hist;
    logic [W-1:0] result;
    logic         newBit;
    case (sel)
      prbsPkg::PRBS7: begin
        tapA = 7;
        tapB = 6;
      end
      prbsPkg::PRBS15: begin
        tapA = 15;
        tapB = 14;
      end
      prbsPkg::PRBS23: begin
        tapA = 23;
        tapB = 18;
      end
      default: begin
        tapA = 31;
        tapB = 28;
      end
    endcase
    for (int d = 1; d <= W; d++) begin
      hist[d-1] = cur[W-d];
    end
    for (int i = 0; i < W; i++) begin
      newBit    = hist[tapA-1] ^ hist[tapB-1];
      result[i] = newBit;
      hist      = {hist[W-2:0], newBit};
    end
    return result;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checkCount++;
    assert (expected === actual) else begin
      errorCount++;
      $display("Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // each call checks what the last edge produced and then drives the next inputs
  task automatic stepCycle();
    logic [63:0]  randWide;
    logic [W-1:0] flip;
    logic         expFlag;
    logic         wasLocked;
    int unsigned  draw;
    @(posedge clk);
    #1;
    checkValue("txValid", 64'(pendValid), 64'(txValid));
    if (pendValid) begin
      checkValue("txData", 64'(pendWord), 64'(txData));
    end
    // the checker sampled the word driven in the previous step
    wasLocked = modelLocked;
    expFlag   = drivenValid && wasLocked && (drivenMask != '0);
    if (drivenValid) begin
      rxWordCount++;
      if (wasLocked) begin
        bitTally  = bitTally + 64'($countones(drivenMask));
        wordTally = wordTally + 64'(drivenMask != '0);
      end
      if (rxWordCount == LockWords) begin
        modelLocked = 1'b1;
      end
    end
    checkValue("locked", 64'(modelLocked), 64'(locked));
    checkValue("errorFlag", 64'(expFlag), 64'(errorFlag));
    // loop back the word on txData and flip bits only once locked
    flip = '0;
    draw = $random(seed);
    if (txValid && modelLocked && flipRate != 0 && (draw % flipRate) == 0) begin
      randWide = {32'($random(seed)), 32'($random(seed))};
      flip     = randWide[W-1:0];
      if (flip == '0) begin
        flip[0] = 1'b1;
      end
    end
    rxValid     = txValid;
    rxData      = txData ^ flip;
    drivenValid = txValid;
    drivenMask  = {{(W-1){1'b0}}, pendIns} ^ flip;
    // an insert waits for the next enabled generator cycle
    draw        = $random(seed);
    genEnable   = (draw[1:0] != 2'b00);
    insertError = wantInsert && genEnable;
    if (genEnable) begin
      pendWord  = modelWord ^ {{(W-1){1'b0}}, insertError};
      pendIns   = insertError;
      modelWord = advanceWord(modelWord, patternSel);
      if (insertError) begin
        wantInsert = 1'b0;
      end
    end
    pendValid = genEnable;
  endtask

  task automatic runCycles(input int count);
    repeat (count) stepCycle();
  endtask

  task automatic resetDut();
    nreset      = 1'b0;
    genEnable   = 1'b0;
    insertError = 1'b0;
    rxData      = '0;
    rxValid     = 1'b0;
    readReq     = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    nreset      = 1'b1;
    modelWord   = W'(`PRBS_SEED);
    pendWord    = '0;
    pendValid   = 1'b0;
    pendIns     = 1'b0;
    drivenValid = 1'b0;
    drivenMask  = '0;
    rxWordCount = 0;
    modelLocked = 1'b0;
    wantInsert  = 1'b0;
    flipRate    = 0;
    bitTally    = '0;
    wordTally   = '0;
  endtask

  // four-phase read while the lane keeps running
  task automatic hostRead(output logic [63:0] bits, output logic [63:0] words);
    int waitCycles;
    readReq    = 1'b1;
    waitCycles = 0;
    while (readAck !== 1'b1 && waitCycles < 8) begin
      stepCycle();
      waitCycles++;
    end
    assert (readAck === 1'b1) else begin
      errorCount++;
      $display("Error: readAck did not rise within 8 cycles of readReq");
    end
    checkValue("readAck rise delay", 64'd2, 64'(waitCycles));
    bits       = 64'(readTotals.bitErrors);
    words      = 64'(readTotals.wordErrors);
    readReq    = 1'b0;
    waitCycles = 0;
    while (readAck !== 1'b0 && waitCycles < 8) begin
      stepCycle();
      waitCycles++;
    end
    checkValue("readAck fall delay", 64'd2, 64'(waitCycles));
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin : mainSequence
    logic [63:0] bitsA;
    logic [63:0] wordsA;
    logic [63:0] bitsB;
    logic [63:0] wordsB;
    errorCount   = 0;
    checkCount   = 0;
    seed         = 91157;
    patternSel   = prbsPkg::PRBS7;
    for (int p = 0; p < 4; p++) begin
      patternSel = prbsPkg::prbsPattern_e'(p);
      resetDut();
      // clean lane with gaps while lock is checked every cycle
      runCycles(60);
      checkValue("locked", 64'd1, 64'(locked));
      // sparse random flips on about one word in twenty
      flipRate = 20;
      runCycles(200);
      flipRate = 0;
      runCycles(6);
      hostRead(bitsA, wordsA);
      checkValue("readTotals.bitErrors", bitTally, bitsA);
      checkValue("readTotals.wordErrors", wordTally, wordsA);
      bitTally  = '0;
      wordTally = '0;
      // three single-bit inserts followed by a read and a read of the cleared counts
      repeat (3) begin
        wantInsert = 1'b1;
        while (wantInsert) stepCycle();
        runCycles(8);
      end
      hostRead(bitsA, wordsA);
      checkValue("readTotals.bitErrors", 64'd3, bitsA);
      checkValue("readTotals.wordErrors", 64'd3, wordsA);
      hostRead(bitsB, wordsB);
      checkValue("readTotals.bitErrors", 64'd0, bitsB);
      checkValue("readTotals.wordErrors", 64'd0, wordsB);
      bitTally  = '0;
      wordTally = '0;
      // a read in the middle of heavy errors must not drop any count
      flipRate = 3;
      runCycles(20);
      hostRead(bitsA, wordsA);
      runCycles(20);
      flipRate = 0;
      runCycles(6);
      hostRead(bitsB, wordsB);
      checkValue("summed bitErrors", bitTally, bitsA + bitsB);
      checkValue("summed wordErrors", wordTally, wordsA + wordsB);
    end
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < MaxCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Error: run did not finish within %0d cycles", MaxCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/prbsPkg.sv
src/prbsPoly.sv
src/prbsGenerator.sv
src/prbsChecker.sv
src/errorCounter.sv
src/prbsTester.sv
verif/prbsTesterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the PRBS link tester testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

TOP=prbsTesterTb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0
